//--- rtl/lsu_pkg.sv
/* Load/store unit package with widths, opcodes, function codes,
   exception codes and the queued record types */
package lsu_pkg;

    ////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////
    localparam int XLEN = 32;
    localparam int ID_W = 4;

    typedef logic [ID_W-1:0] id_t;

    // Local data memory, word addressed, address wraps
    localparam int RAM_WORDS = 1024;
    localparam int RAM_ADDR_W = 10;

    localparam int REQ_DEPTH = 4;
    localparam int ATTR_DEPTH = 2;

    ////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_FENCE = 7'b0001111;

    // Access width codes in fn3
    localparam logic [2:0] FN3_B = 3'b000;
    localparam logic [2:0] FN3_H = 3'b001;
    localparam logic [2:0] FN3_W = 3'b010;
    localparam logic [2:0] FN3_BU = 3'b100;
    localparam logic [2:0] FN3_HU = 3'b101;

    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_LOAD_MISALIGNED = 5'd4;
    localparam exc_code_t EXC_STORE_MISALIGNED = 5'd6;

    ////////////////////////////////////////
    // Record types
    ////////////////////////////////////////

    // One memory operation waiting for the data memory
    typedef struct packed {
        logic [RAM_ADDR_W-1:0] word_addr;
        logic [3:0]            be;
        logic [XLEN-1:0]       data;
        logic                  is_load;
        logic [2:0]            fn3;
        logic [1:0]            byte_offset;
        id_t                   id;
    } ls_request_t;

    // Load in flight, kept until its read data returns
    typedef struct packed {
        id_t        id;
        logic [1:0] byte_offset;
        logic [1:0] width_sel;
        logic       is_signed;
    } load_attr_t;

endpackage

//--- rtl/lsu_queue.sv
/* Synchronous FIFO with a circular buffer, generic over its payload type */
module lsu_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     valid,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t entries [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= data_in;
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is visible without a read strobe
    assign data_out = entries[rd_ptr];
    assign valid = (count != '0);
    assign full = (count == CNT_W'(DEPTH));

endmodule

//--- rtl/lsu_decode.sv
/* Load/store decode: effective address, byte enables, store lane
   replication and misalignment detection */
module lsu_decode (
    input  logic [31:0]          instruction,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    input  lsu_pkg::id_t         id,
    output lsu_pkg::ls_request_t request,
    output logic                 is_fence,
    output logic                 is_store,
    output logic                 misaligned,
    output logic [31:0]          exc_addr
);
    import lsu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      fn3;
    logic            is_load;
    logic [11:0]     offset;
    logic [XLEN-1:0] addr;
    logic [3:0]      be;
    logic [XLEN-1:0] lane_data;
    logic            size_half;
    logic            size_word;

    assign opcode = instruction[6:0];
    assign fn3 = instruction[14:12];

    assign is_load = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);
    assign is_fence = (opcode == OPC_FENCE);

    // S-type splits the immediate around rd
    assign offset = is_store ? {instruction[31:25], instruction[11:7]} : instruction[31:20];
    assign addr = rs1_data + {{20{offset[11]}}, offset};

    ////////////////////////////////////////
    // Byte enables and store lanes
    ////////////////////////////////////////
    always_comb begin
        be = 4'b1111;
        lane_data = rs2_data;
        size_half = 1'b0;
        size_word = 1'b0;
        case (fn3)
            FN3_B, FN3_BU: begin
                be = 4'b0001 << addr[1:0];
                lane_data = {4{rs2_data[7:0]}};
            end
            FN3_H, FN3_HU: begin
                be = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{rs2_data[15:0]}};
                size_half = 1'b1;
            end
            FN3_W: begin
                size_word = 1'b1;
            end
            default: begin
                size_word = 1'b1;
            end
        endcase
    end

    // Fence is neither load nor store, so never misaligned
    assign misaligned = (is_load | is_store) &
                        ((size_half & addr[0]) | (size_word & (addr[1:0] != 2'b00)));

    assign request = '{
        word_addr:   addr[RAM_ADDR_W+1:2],
        be:          be,
        data:        lane_data,
        is_load:     is_load,
        fn3:         fn3,
        byte_offset: addr[1:0],
        id:          id
    };

    assign exc_addr = addr;

endmodule

//--- rtl/lsu_control.sv
/* Issue control FSM: accept, fence wait until idle, and misaligned
   exception capture with acknowledge */
module lsu_control (
    input  logic               clk,
    input  logic               rst,
    input  logic               new_request,
    input  logic               is_fence,
    input  logic               is_store,
    input  logic               misaligned,
    input  logic [31:0]        exc_addr,
    input  lsu_pkg::id_t       id,
    input  logic               queue_full,
    input  logic               pending_zero,
    input  logic               exception_ack,
    output logic               issue_ready,
    output logic               accept,
    output logic               exception_valid,
    output lsu_pkg::exc_code_t exception_code,
    output logic [31:0]        exception_tval,
    output lsu_pkg::id_t       exception_id,
    output logic               exc_wb_done
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        RUN,
        FENCE_WAIT,
        EXCEPTION
    } state_t;

    state_t state;
    state_t state_next;

    assign issue_ready = (state == RUN) & ~queue_full;
    assign accept = new_request & issue_ready;
    assign exception_valid = (state == EXCEPTION);

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (accept & misaligned)
                    state_next = EXCEPTION;
                else if (accept & is_fence)
                    state_next = FENCE_WAIT;
            end
            // Leave once every queued operation has finished
            FENCE_WAIT: begin
                if (pending_zero)
                    state_next = RUN;
            end
            EXCEPTION: begin
                if (exception_ack)
                    state_next = RUN;
            end
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= RUN;
        else
            state <= state_next;
    end

    // Exception details, stable while in EXCEPTION
    always_ff @(posedge clk) begin
        if (accept & misaligned) begin
            exception_code <= is_store ? EXC_STORE_MISALIGNED : EXC_LOAD_MISALIGNED;
            exception_tval <= exc_addr;
            exception_id <= id;
        end
    end

    // A faulting load still owes a writeback completion
    always_ff @(posedge clk) begin
        if (rst)
            exc_wb_done <= 1'b0;
        else
            exc_wb_done <= exception_valid & exception_ack &
                           (exception_code == EXC_LOAD_MISALIGNED);
    end

endmodule

//--- rtl/lsu_pending_counter.sv
/* Outstanding memory operation counter */
module lsu_pending_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       inc,
    // A store pop and a load's read data can finish in the same cycle
    input  logic [1:0] dec,
    output logic       pending_zero
);
    import lsu_pkg::*;

    // Queued requests plus loads waiting on read data
    localparam int CNT_W = $clog2(REQ_DEPTH + ATTR_DEPTH + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(inc) - CNT_W'(dec);
        end
    end

    assign pending_zero = (count == '0);

endmodule

//--- rtl/lsu_data_ram.sv
/* Local data memory, byte-enabled writes and one-cycle registered reads */
module lsu_data_ram (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  lsu_pkg::ls_request_t req,
    output logic [31:0]          read_data,
    output logic                 read_valid
);
    import lsu_pkg::*;

    logic [XLEN-1:0] mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (req_valid & ~req.is_load) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i])
                    mem[req.word_addr][i*8 +: 8] <= req.data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid & req.is_load)
            read_data <= mem[req.word_addr];
    end

    // Data strobe for the aligner and attribute queue
    always_ff @(posedge clk) begin
        if (rst)
            read_valid <= 1'b0;
        else
            read_valid <= req_valid & req.is_load;
    end

endmodule

//--- rtl/lsu_load_align.sv
/* Load alignment with sign extension and writeback port merge */
module lsu_load_align (
    input  logic                read_valid,
    input  logic [31:0]         read_data,
    input  lsu_pkg::load_attr_t attr,
    input  logic                exc_wb_done,
    input  lsu_pkg::id_t        exception_id,
    output logic                wb_done,
    output lsu_pkg::id_t        wb_id,
    output logic [31:0]         wb_data
);
    import lsu_pkg::*;

    logic [7:0]  byte_data;
    logic [15:0] half_data;
    logic        sign_bit;

    assign byte_data = read_data[attr.byte_offset*8 +: 8];
    assign half_data = attr.byte_offset[1] ? read_data[31:16] : read_data[15:0];

    always_comb begin
        sign_bit = 1'b0;
        wb_data = read_data;
        case (attr.width_sel)
            FN3_B[1:0]: begin
                sign_bit = attr.is_signed & byte_data[7];
                wb_data = {{24{sign_bit}}, byte_data};
            end
            FN3_H[1:0]: begin
                sign_bit = attr.is_signed & half_data[15];
                wb_data = {{16{sign_bit}}, half_data};
            end
            default: wb_data = read_data;
        endcase
    end

    // Exception completion wins the port
    // Issue is stopped until the ack, so only older loads could be draining
    assign wb_done = read_valid | exc_wb_done;
    assign wb_id = exc_wb_done ? exception_id : attr.id;

endmodule

//--- rtl/lsu_top.sv
/* In-order load/store unit with local data memory, fence hold,
   misaligned exceptions and tagged load writeback */
module lsu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               new_request,
    input  logic [31:0]        instruction,
    input  logic [31:0]        rs1_data,
    input  logic [31:0]        rs2_data,
    input  lsu_pkg::id_t       id,
    output logic               issue_ready,
    output logic               exception_valid,
    output lsu_pkg::exc_code_t exception_code,
    output logic [31:0]        exception_tval,
    output lsu_pkg::id_t       exception_id,
    input  logic               exception_ack,
    output logic               wb_done,
    output lsu_pkg::id_t       wb_id,
    output logic [31:0]        wb_data,
    output logic               idle
);
    import lsu_pkg::*;

    ls_request_t     request;
    logic            is_fence;
    logic            is_store;
    logic            misaligned;
    logic [XLEN-1:0] exc_addr;
    logic            accept;
    logic            exc_wb_done;

    logic            req_push;
    logic            req_valid;
    logic            req_full;
    ls_request_t     req_head;

    load_attr_t      attr_in;
    load_attr_t      attr_head;
    logic            attr_push;
    logic            attr_pop;
    logic            attr_valid;

    logic [XLEN-1:0] ram_read_data;
    logic            ram_read_valid;
    logic [1:0]      count_dec;
    logic            pending_zero;

    ////////////////////////////////////////
    // Issue
    ////////////////////////////////////////
    lsu_decode u_decode (
        .instruction (instruction),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id          (id),
        .request     (request),
        .is_fence    (is_fence),
        .is_store    (is_store),
        .misaligned  (misaligned),
        .exc_addr    (exc_addr)
    );

    lsu_control u_control (
        .clk             (clk),
        .rst             (rst),
        .new_request     (new_request),
        .is_fence        (is_fence),
        .is_store        (is_store),
        .misaligned      (misaligned),
        .exc_addr        (exc_addr),
        .id              (id),
        .queue_full      (req_full),
        .pending_zero    (pending_zero),
        .exception_ack   (exception_ack),
        .issue_ready     (issue_ready),
        .accept          (accept),
        .exception_valid (exception_valid),
        .exception_code  (exception_code),
        .exception_tval  (exception_tval),
        .exception_id    (exception_id),
        .exc_wb_done     (exc_wb_done)
    );

    ////////////////////////////////////////
    // Queues and memory
    ////////////////////////////////////////
    assign req_push = accept & ~misaligned & ~is_fence;

    // Memory is always ready, so the head leaves every cycle
    lsu_queue #(.payload_t(ls_request_t), .DEPTH(REQ_DEPTH)) u_req_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (req_push),
        .pop      (req_valid),
        .data_in  (request),
        .data_out (req_head),
        .valid    (req_valid),
        .full     (req_full)
    );

    assign attr_push = req_valid & req_head.is_load;
    assign attr_pop = ram_read_valid & attr_valid;
    assign attr_in = '{
        id:          req_head.id,
        byte_offset: req_head.byte_offset,
        width_sel:   req_head.fn3[1:0],
        is_signed:   ~req_head.fn3[2]
    };

    lsu_queue #(.payload_t(load_attr_t), .DEPTH(ATTR_DEPTH)) u_attr_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (attr_push),
        .pop      (attr_pop),
        .data_in  (attr_in),
        .data_out (attr_head),
        .valid    (attr_valid),
        .full     ()
    );

    lsu_data_ram u_data_ram (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req_head),
        .read_data  (ram_read_data),
        .read_valid (ram_read_valid)
    );

    // Stores finish at their pop, loads when read data returns
    assign count_dec = {1'b0, req_valid & ~req_head.is_load} + {1'b0, ram_read_valid};

    lsu_pending_counter u_pending_counter (
        .clk          (clk),
        .rst          (rst),
        .inc          (req_push),
        .dec          (count_dec),
        .pending_zero (pending_zero)
    );

    assign idle = pending_zero;

    lsu_load_align u_load_align (
        .read_valid   (ram_read_valid),
        .read_data    (ram_read_data),
        .attr         (attr_head),
        .exc_wb_done  (exc_wb_done),
        .exception_id (exception_id),
        .wb_done      (wb_done),
        .wb_id        (wb_id),
        .wb_data      (wb_data)
    );

endmodule

//--- tests/lsu_sva.sv
/* Protocol assertions for the load/store unit, bound to its top level */
module lsu_sva (
    input logic               clk,
    input logic               rst,
    input logic               exception_valid,
    input logic               exception_ack,
    input lsu_pkg::exc_code_t exception_code,
    input logic [31:0]        exception_tval,
    input lsu_pkg::id_t       exception_id,
    input logic               wb_done,
    input lsu_pkg::id_t       wb_id,
    input logic               idle,
    input logic               exc_wb_done
);
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;

    // A faulting load completes on the writeback port right after its ack
    a_exc_completion: assert property (@(posedge clk) disable iff (rst)
        exception_valid && exception_ack && (exception_code == EXC_LOAD_MISALIGNED) |=>
            wb_done && (wb_id == $past(exception_id)))
        else $error("no writeback completion after the ack of a load exception");

    // Details hold until the ack
    a_exc_stable: assert property (@(posedge clk) disable iff (rst)
        exception_valid && !exception_ack |=>
            $stable(exception_code) && $stable(exception_tval) && $stable(exception_id))
        else $error("exception details changed before the ack");

    a_no_wb_when_idle: assert property (@(posedge clk) disable iff (rst)
        wb_done && idle |-> exc_wb_done)
        else $error("load writeback while the unit is idle");

endmodule

bind lsu_top lsu_sva u_sva (
    .clk             (clk),
    .rst             (rst),
    .exception_valid (exception_valid),
    .exception_ack   (exception_ack),
    .exception_code  (exception_code),
    .exception_tval  (exception_tval),
    .exception_id    (exception_id),
    .wb_done         (wb_done),
    .wb_id           (wb_id),
    .idle            (idle),
    .exc_wb_done     (exc_wb_done)
);

//--- tests/lsu_tb.sv
/* Load/store unit testbench with a reference memory model, in-order
   writeback checking, fences and misaligned exceptions */
module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;

    localparam int TIMEOUT = 200;
    localparam logic [31:0] FENCE_INSN = 32'h0ff0000f;

    // One writeback the DUT still owes
    typedef struct packed {
        id_t         id;
        logic [31:0] data;
        logic        is_exc;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        new_request;
    logic [31:0] instruction;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    id_t         id;
    logic        issue_ready;
    logic        exception_valid;
    exc_code_t   exception_code;
    logic [31:0] exception_tval;
    id_t         exception_id;
    logic        exception_ack;
    logic        wb_done;
    id_t         wb_id;
    logic [31:0] wb_data;
    logic        idle;

    logic [31:0] model_mem [RAM_WORDS];
    expect_t     exp_q [$];
    logic [31:0] seed;
    id_t         next_id;
    int          error_count;

    lsu_top i_dut (
        .clk             (clk),
        .rst             (rst),
        .new_request     (new_request),
        .instruction     (instruction),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .id              (id),
        .issue_ready     (issue_ready),
        .exception_valid (exception_valid),
        .exception_code  (exception_code),
        .exception_tval  (exception_tval),
        .exception_id    (exception_id),
        .exception_ack   (exception_ack),
        .wb_done         (wb_done),
        .wb_id           (wb_id),
        .wb_data         (wb_data),
        .idle            (idle)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers and reference model
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = lcg_next(seed);
        r = seed;
    endtask

    function automatic logic [31:0] effective_addr(input logic [31:0] base,
                                                   input logic [11:0] off);
        return base + {{20{off[11]}}, off};
    endfunction

    function automatic logic [31:0] load_insn(input logic [2:0] fn3, input logic [11:0] off);
        return {off, 5'd2, fn3, 5'd1, OPC_LOAD};
    endfunction

    function automatic logic [31:0] store_insn(input logic [2:0] fn3, input logic [11:0] off);
        return {off[11:5], 5'd3, 5'd2, fn3, off[4:0], OPC_STORE};
    endfunction

    // Expected load result, memory indexed by address bits 11:2
    function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [2:0] fn3);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = model_mem[addr[11:2]];
        b = w[addr[1:0]*8 +: 8];
        h = addr[1] ? w[31:16] : w[15:0];
        case (fn3)
            FN3_B:   return {{24{b[7]}}, b};
            FN3_H:   return {{16{h[15]}}, h};
            FN3_BU:  return {24'b0, b};
            FN3_HU:  return {16'b0, h};
            default: return w;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] addr, input logic [2:0] fn3,
                               input logic [31:0] data);
        case (fn3)
            FN3_B:   model_mem[addr[11:2]][addr[1:0]*8 +: 8] = data[7:0];
            FN3_H:   model_mem[addr[11:2]][addr[1]*16 +: 16] = data[15:0];
            default: model_mem[addr[11:2]] = data;
        endcase
    endtask

    task automatic fail_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
            fail_run($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                               $time, what, actual, expected));
    endtask

    ////////////////////////////////////////
    // Bounded waits
    ////////////////////////////////////////
    task automatic wait_ready();
        int n;
        n = 0;
        while (!issue_ready) begin
            if (n == TIMEOUT)
                fail_run("Timed out waiting for issue_ready to rise");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (!idle) begin
            if (n == TIMEOUT)
                fail_run("Timed out waiting for the unit to become idle");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 || !idle) begin
            if (n == TIMEOUT)
                fail_run("Timed out waiting for outstanding loads to complete");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    ////////////////////////////////////////
    // Issue tasks
    ////////////////////////////////////////
    task automatic issue_op(input logic [31:0] insn, input logic [31:0] rs1,
                            input logic [31:0] rs2, output id_t used_id);
        wait_ready();
        new_request = 1'b1;
        instruction = insn;
        rs1_data = rs1;
        rs2_data = rs2;
        id = next_id;
        used_id = next_id;
        @(posedge clk);
        #1;
        new_request = 1'b0;
        next_id = next_id + 1'b1;
    endtask

    task automatic do_load(input logic [2:0] fn3, input logic [31:0] base,
                           input logic [11:0] off);
        expect_t e;
        id_t     used;
        e.data = ref_load(effective_addr(base, off), fn3);
        e.is_exc = 1'b0;
        issue_op(load_insn(fn3, off), base, 32'h0, used);
        e.id = used;
        exp_q.push_back(e);
    endtask

    task automatic do_store(input logic [2:0] fn3, input logic [31:0] base,
                            input logic [11:0] off, input logic [31:0] data);
        id_t used;
        issue_op(store_insn(fn3, off), base, data, used);
        model_store(effective_addr(base, off), fn3, data);
    endtask

    ////////////////////////////////////////
    // Writeback comparison
    ////////////////////////////////////////
    always @(negedge clk) begin : compare_wb
        expect_t e;
        if (!rst && wb_done) begin
            if (exp_q.size() == 0) begin
                fail_run("Writeback completion arrived with nothing outstanding");
            end else begin
                e = exp_q.pop_front();
                check_value(wb_id, e.id, "wb_id");
                if (!e.is_exc)
                    check_value(wb_data, e.data, "wb_data");
            end
        end
    end

    ////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////
    task automatic check_reset();
        check_value(issue_ready, 1, "issue_ready after reset");
        check_value(idle, 1, "idle after reset");
        check_value(wb_done, 0, "wb_done after reset");
        check_value(exception_valid, 0, "exception_valid after reset");
    endtask

    // Word region 0x400..0x4ff used by the random mix
    task automatic fill_region();
        logic [31:0] addr;
        for (int i = 0; i < 64; i++) begin
            addr = 32'h400 + 4 * i;
            do_store(FN3_W, 32'h400, 12'(4 * i),
                     (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]});
        end
    endtask

    task automatic directed_widths();
        do_store(FN3_W, 32'h500, 12'h000, 32'h80f1_7e92);
        do_store(FN3_W, 32'h500, 12'h004, 32'h1234_c567);
        do_store(FN3_W, 32'h500, 12'h008, 32'h0000_0000);
        do_store(FN3_H, 32'h500, 12'h006, 32'hffff_9abc);
        do_store(FN3_B, 32'h500, 12'h009, 32'h0000_0085);
        do_store(FN3_B, 32'h500, 12'h00b, 32'h0000_0071);
        do_load(FN3_W, 32'h500, 12'h000);
        do_load(FN3_W, 32'h500, 12'h004);
        do_load(FN3_W, 32'h500, 12'h008);
        do_load(FN3_H, 32'h500, 12'h006);
        do_load(FN3_HU, 32'h500, 12'h006);
        do_load(FN3_H, 32'h500, 12'h004);
        do_load(FN3_HU, 32'h500, 12'h002);
        do_load(FN3_B, 32'h500, 12'h009);
        do_load(FN3_BU, 32'h500, 12'h009);
        do_load(FN3_B, 32'h500, 12'h00b);
        do_load(FN3_B, 32'h500, 12'h003);
        do_load(FN3_BU, 32'h500, 12'h001);
        // Negative offset back onto the first word
        do_load(FN3_W, 32'h50c, 12'hff4);
        wait_drained();
    endtask

    task automatic random_mix(input int count);
        logic [31:0] r;
        logic [31:0] d;
        logic [7:0]  a;
        logic [31:0] base;
        logic [11:0] off;
        logic [2:0]  fn3;
        for (int i = 0; i < count; i++) begin
            next_rand(r);
            next_rand(d);
            if (r[24]) begin
                case (r[27:25] % 5)
                    0: fn3 = FN3_B;
                    1: fn3 = FN3_H;
                    2: fn3 = FN3_W;
                    3: fn3 = FN3_BU;
                    default: fn3 = FN3_HU;
                endcase
            end else begin
                case (r[27:25] % 3)
                    0: fn3 = FN3_B;
                    1: fn3 = FN3_H;
                    default: fn3 = FN3_W;
                endcase
            end
            case (fn3)
                FN3_B, FN3_BU: a = {r[21:16], r[29:28]};
                FN3_H, FN3_HU: a = {r[21:16], r[29], 1'b0};
                default: a = {r[21:16], 2'b00};
            endcase
            // Three address forms that all land in the same words
            case (r[31:30] % 3)
                0: begin
                    base = 32'h400;
                    off = {4'b0, a};
                end
                1: begin
                    base = 32'h8000_0400;
                    off = {4'b0, a};
                end
                default: begin
                    base = 32'h0c00;
                    off = 12'h800 + a;
                end
            endcase
            if (r[24])
                do_load(fn3, base, off);
            else
                do_store(fn3, base, off, d);
            repeat (r[13:12] % 3) begin
                @(posedge clk);
                #1;
            end
        end
        wait_drained();
        // Nothing left to finish, so the unit must stay idle
        @(posedge clk);
        #1;
        check_value(idle, 1, "idle one cycle after the random mix drained");
    endtask

    task automatic misaligned_case(input logic [31:0] insn, input logic [31:0] base,
                                   input logic is_load, input logic [31:0] tval);
        id_t     used;
        expect_t e;
        wait_idle();
        issue_op(insn, base, 32'h5a5a_0ff0, used);
        check_value(exception_valid, 1, "exception_valid after misaligned accept");
        check_value(exception_code, is_load ? EXC_LOAD_MISALIGNED : EXC_STORE_MISALIGNED,
                    "exception_code");
        check_value(exception_tval, tval, "exception_tval");
        check_value(exception_id, used, "exception_id");
        repeat (2) begin
            @(posedge clk);
            #1;
            check_value(issue_ready, 0, "issue_ready during exception");
        end
        exception_ack = 1'b1;
        if (is_load) begin
            e.id = used;
            e.data = '0;
            e.is_exc = 1'b1;
            exp_q.push_back(e);
        end
        @(posedge clk);
        #1;
        exception_ack = 1'b0;
        check_value(exception_valid, 0, "exception_valid after ack");
        check_value(wb_done, is_load, "wb_done one cycle after exception_ack");
        if (is_load)
            check_value(wb_id, used, "wb_id of exception completion");
    endtask

    task automatic misaligned_tests();
        misaligned_case(load_insn(FN3_H, 12'h001), 32'h500, 1'b1, 32'h501);
        misaligned_case(load_insn(FN3_W, 12'h006), 32'h500, 1'b1, 32'h506);
        misaligned_case(load_insn(FN3_HU, 12'hfff), 32'h508, 1'b1, 32'h507);
        misaligned_case(store_insn(FN3_W, 12'h003), 32'h500, 1'b0, 32'h503);
        misaligned_case(store_insn(FN3_H, 12'h005), 32'h500, 1'b0, 32'h505);
        // Words under the faulting stores must be unchanged
        do_load(FN3_W, 32'h500, 12'h000);
        do_load(FN3_W, 32'h500, 12'h004);
        wait_drained();
    endtask

    task automatic fence_test();
        id_t unused;
        int  n;
        do_store(FN3_W, 32'h500, 12'h010, 32'h3c3c_a5a5);
        do_load(FN3_W, 32'h500, 12'h010);
        do_load(FN3_B, 32'h500, 12'h011);
        do_store(FN3_H, 32'h500, 12'h012, 32'h0000_e001);
        issue_op(FENCE_INSN, 32'h0, 32'h0, unused);
        n = 0;
        forever begin
            check_value(issue_ready, 0, "issue_ready while fence waits");
            if (idle)
                break;
            if (n == TIMEOUT)
                fail_run("Timed out waiting for the fence to drain");
            @(posedge clk);
            #1;
            n++;
        end
        do_load(FN3_H, 32'h500, 12'h012);
        do_load(FN3_W, 32'h500, 12'h010);
        wait_drained();
    endtask

    initial begin : stimulus
        rst = 1'b1;
        new_request = 1'b0;
        instruction = '0;
        rs1_data = '0;
        rs2_data = '0;
        id = '0;
        exception_ack = 1'b0;
        next_id = '0;
        error_count = 0;
        seed = 32'he96486a9;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset();
        fill_region();
        directed_widths();
        random_mix(300);
        misaligned_tests();
        fence_test();
        wait_drained();
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- flist.f
rtl/lsu_pkg.sv
rtl/lsu_queue.sv
rtl/lsu_decode.sv
rtl/lsu_control.sv
rtl/lsu_pending_counter.sv
rtl/lsu_data_ram.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
tests/lsu_sva.sv
tests/lsu_tb.sv
